// ==== include/mcu_defs_defs.svh ====
// ----------------------------------------
// widths, bank geometry, switch delay and
// register indices of the mini mcu
// ----------------------------------------
`ifndef MCU_DEFS_DEFS_SVH
`define MCU_DEFS_DEFS_SVH

`define MCU_DATA_W 32
`define MCU_ADDR_W 16
`define MCU_NUM_BANKS 4
`define MCU_BANK_WORDS 64
`define MCU_GPIO_W 8

// cycles from switch change to acknowledge
`define MCU_SWITCH_ACK_DELAY 4

// power manager registers
`define MCU_PM_REG_OFF 2'd0
`define MCU_PM_REG_RET 2'd1
`define MCU_PM_REG_STATUS 2'd2

// always-on gpio registers
`define MCU_GPIO_REG_OUT 2'd0
`define MCU_GPIO_REG_OE 2'd1
`define MCU_GPIO_REG_IN 2'd2
`define MCU_GPIO_REG_IE 2'd3

`endif

// ==== rtl/mcu_pkg.sv ====
// ----------------------------------------
// address views, block and power state types
// ----------------------------------------
package mcu_pkg;

  typedef enum logic [1:0] {
    BLK_PM    = 2'd0,
    BLK_GPIO  = 2'd1,
    BLK_RSVD2 = 2'd2,
    BLK_RSVD3 = 2'd3
  } periph_block_e;

  typedef enum logic [2:0] {
    PWR_ON         = 3'd0,
    PWR_GATE       = 3'd1,
    PWR_SWITCH_OFF = 3'd2,
    PWR_OFF        = 3'd3,
    PWR_SWITCH_ON  = 3'd4
  } pwr_state_e;

  // region 0 is ram
  typedef struct packed {
    logic       region;
    logic [4:0] unused;
    logic [1:0] bank;
    logic [5:0] word;
    logic [1:0] byte_sel;
  } mcu_ram_addr_t;

  // region 1 is peripherals
  typedef struct packed {
    logic          region;
    logic [8:0]    unused;
    periph_block_e block;
    logic [1:0]    reg_idx;
    logic [1:0]    byte_sel;
  } mcu_periph_addr_t;

  typedef union packed {
    mcu_ram_addr_t    ram;
    mcu_periph_addr_t periph;
  } mcu_addr_u;

endpackage

// ==== rtl/mcu_if.sv ====
// ----------------------------------------
// wishbone and bank power interfaces
// ----------------------------------------
`timescale 1ns/1ps
`include "mcu_defs_defs.svh"

interface wb_if import mcu_pkg::*; ();
  logic                   cyc;
  logic                   stb;
  logic                   we;
  mcu_addr_u              adr;
  logic [`MCU_DATA_W-1:0] dat_w;
  logic [`MCU_DATA_W-1:0] dat_r;
  logic                   ack;

  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack
  );
endinterface

// one active-low bit per bank
interface pwr_if ();
  logic [`MCU_NUM_BANKS-1:0] clkgate_en_n;
  logic [`MCU_NUM_BANKS-1:0] iso_n;
  logic [`MCU_NUM_BANKS-1:0] switch_n;
  logic [`MCU_NUM_BANKS-1:0] retentive_n;
  logic [`MCU_NUM_BANKS-1:0] switch_ack_n;

  modport ctrl (
    output clkgate_en_n, iso_n, switch_n, retentive_n,
    input  switch_ack_n
  );

  modport bank (
    input  clkgate_en_n, iso_n, switch_n, retentive_n,
    output switch_ack_n
  );
endinterface

// ==== rtl/system_bus.sv ====
// ----------------------------------------
// registered address decoder for one master
// ----------------------------------------
`timescale 1ns/1ps
`include "mcu_defs_defs.svh"

module system_bus import mcu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [`MCU_ADDR_W-1:0] wb_adr_i,
  input  logic [`MCU_DATA_W-1:0] wb_dat_i,
  output logic [`MCU_DATA_W-1:0] wb_dat_o,
  output logic                   wb_ack_o,
  wb_if.master                   mem_o,
  wb_if.master                   pm_o,
  wb_if.master                   gpio_o
);
  mcu_addr_u              adr_in;
  mcu_addr_u              adr_q;
  logic                   we_q;
  logic [`MCU_DATA_W-1:0] dat_q;
  logic                   req_q;
  logic                   sel_mem_d, sel_pm_d, sel_gpio_d;
  logic                   sel_mem_q, sel_pm_q, sel_gpio_q;
  logic                   unm_ack_q;
  logic                   start;

  assign adr_in = wb_adr_i;
  assign start  = wb_cyc_i & wb_stb_i & ~req_q;

  // region first, then block
  always_comb begin
    sel_mem_d  = 1'b0;
    sel_pm_d   = 1'b0;
    sel_gpio_d = 1'b0;
    if (!adr_in.ram.region) begin
      sel_mem_d = 1'b1;
    end else begin
      case (adr_in.periph.block)
        BLK_PM:   sel_pm_d = 1'b1;
        BLK_GPIO: sel_gpio_d = 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_q      <= 1'b0;
      sel_mem_q  <= 1'b0;
      sel_pm_q   <= 1'b0;
      sel_gpio_q <= 1'b0;
      unm_ack_q  <= 1'b0;
    end else begin
      // unmapped blocks answer with the same latency as a target
      unm_ack_q <= req_q & ~(sel_mem_q | sel_pm_q | sel_gpio_q) & ~unm_ack_q;
      if (req_q) begin
        if (wb_ack_o) begin
          req_q <= 1'b0;
        end
      end else if (start) begin
        req_q      <= 1'b1;
        sel_mem_q  <= sel_mem_d;
        sel_pm_q   <= sel_pm_d;
        sel_gpio_q <= sel_gpio_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      adr_q <= adr_in;
      we_q  <= wb_we_i;
      dat_q <= wb_dat_i;
    end
  end

  assign mem_o.cyc   = req_q & sel_mem_q;
  assign mem_o.stb   = req_q & sel_mem_q;
  assign mem_o.we    = we_q;
  assign mem_o.adr   = adr_q;
  assign mem_o.dat_w = dat_q;

  assign pm_o.cyc   = req_q & sel_pm_q;
  assign pm_o.stb   = req_q & sel_pm_q;
  assign pm_o.we    = we_q;
  assign pm_o.adr   = adr_q;
  assign pm_o.dat_w = dat_q;

  assign gpio_o.cyc   = req_q & sel_gpio_q;
  assign gpio_o.stb   = req_q & sel_gpio_q;
  assign gpio_o.we    = we_q;
  assign gpio_o.adr   = adr_q;
  assign gpio_o.dat_w = dat_q;

  always_comb begin
    wb_dat_o = '0;
    if (sel_mem_q) begin
      wb_dat_o = mem_o.dat_r;
    end else if (sel_pm_q) begin
      wb_dat_o = pm_o.dat_r;
    end else if (sel_gpio_q) begin
      wb_dat_o = gpio_o.dat_r;
    end
  end

  assign wb_ack_o = mem_o.ack | pm_o.ack | gpio_o.ack | unm_ack_q;

  // a target is active while strobed or acknowledging
  a_one_target: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({mem_o.stb | mem_o.ack, pm_o.stb | pm_o.ack, gpio_o.stb | gpio_o.ack,
              unm_ack_q}));

endmodule

// ==== rtl/memory_subsystem.sv ====
// ----------------------------------------
// banked ram with power switch models
// ----------------------------------------
`timescale 1ns/1ps
`include "mcu_defs_defs.svh"

module memory_subsystem (
  input  logic clk_i,
  input  logic rst_i,
  wb_if.slave  bus_i,
  pwr_if.bank  pwr_i
);
  localparam int NB    = `MCU_NUM_BANKS;
  localparam int WORDS = `MCU_BANK_WORDS;
  localparam int DW    = `MCU_DATA_W;
  localparam int DLY   = `MCU_SWITCH_ACK_DELAY;

  logic [DW-1:0]            mem [NB][WORDS];
  logic [DLY-1:0]           ack_sr [NB];
  logic [NB-1:0]            sw_fall;
  logic [$clog2(NB)-1:0]    bank;
  logic [$clog2(WORDS)-1:0] word;
  logic                     bank_on;
  logic                     access;
  logic                     ack_q;
  logic [DW-1:0]            rdata_q;

  assign bank    = bus_i.adr.ram.bank;
  assign word    = bus_i.adr.ram.word;
  assign bank_on = pwr_i.clkgate_en_n[bank];
  assign access  = bus_i.cyc & bus_i.stb & ~ack_q;

  // switch acknowledge follows the switch after DLY cycles
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int b = 0; b < NB; b++) begin
        ack_sr[b] <= '1;
      end
    end else begin
      for (int b = 0; b < NB; b++) begin
        ack_sr[b] <= {ack_sr[b][DLY-2:0], pwr_i.switch_n[b]};
      end
    end
  end

  // first stage of the delay line holds last cycle's switch
  always_comb begin
    for (int b = 0; b < NB; b++) begin
      pwr_i.switch_ack_n[b] = ack_sr[b][DLY-1];
      sw_fall[b]            = ack_sr[b][0] & ~pwr_i.switch_n[b];
    end
  end

  always_ff @(posedge clk_i) begin
    // contents lost unless retentive
    for (int b = 0; b < NB; b++) begin
      if (sw_fall[b] && pwr_i.retentive_n[b]) begin
        for (int w = 0; w < WORDS; w++) begin
          mem[b][w] <= '0;
        end
      end
    end
    if (access && bus_i.we && bank_on) begin
      mem[bank][word] <= bus_i.dat_w;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // gated bank reads zero
  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= bank_on ? mem[bank][word] : '0;
    end
  end

  assign bus_i.ack   = ack_q;
  assign bus_i.dat_r = rdata_q;

  a_iso_before_switch: assert property (@(posedge clk_i) disable iff (rst_i)
    (sw_fall & pwr_i.iso_n) == '0);

endmodule

// ==== rtl/power_manager.sv ====
// ----------------------------------------
// power registers and bank sequencers
// ----------------------------------------
`timescale 1ns/1ps
`include "mcu_defs_defs.svh"

module power_manager import mcu_pkg::*; (
  input  logic clk_i,
  input  logic rst_i,
  wb_if.slave  bus_i,
  pwr_if.ctrl  pwr_o
);
  localparam int NB = `MCU_NUM_BANKS;
  localparam int DW = `MCU_DATA_W;

  pwr_state_e    state_q [NB];
  pwr_state_e    state_d [NB];
  logic [NB-1:0] off_q;
  logic [NB-1:0] ret_q;
  logic [NB-1:0] status;
  logic          access;
  logic          ack_q;
  logic [DW-1:0] rd_mux;
  logic [DW-1:0] rdata_q;

  assign access = bus_i.cyc & bus_i.stb & ~ack_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      off_q <= '0;
      ret_q <= '0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
      if (access && bus_i.we) begin
        case (bus_i.adr.periph.reg_idx)
          `MCU_PM_REG_OFF: off_q <= bus_i.dat_w[NB-1:0];
          `MCU_PM_REG_RET: ret_q <= bus_i.dat_w[NB-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rd_mux = '0;
    case (bus_i.adr.periph.reg_idx)
      `MCU_PM_REG_OFF:    rd_mux[NB-1:0] = off_q;
      `MCU_PM_REG_RET:    rd_mux[NB-1:0] = ret_q;
      `MCU_PM_REG_STATUS: rd_mux[NB-1:0] = status;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= rd_mux;
    end
  end

  assign bus_i.ack   = ack_q;
  assign bus_i.dat_r = rdata_q;

  // power off gates and isolates before the switch opens
  // power on waits for the switch ack before release
  always_comb begin
    for (int b = 0; b < NB; b++) begin
      state_d[b] = state_q[b];
      case (state_q[b])
        PWR_ON:         if (off_q[b]) state_d[b] = PWR_GATE;
        PWR_GATE:       state_d[b] = PWR_SWITCH_OFF;
        PWR_SWITCH_OFF: if (!pwr_o.switch_ack_n[b]) state_d[b] = PWR_OFF;
        PWR_OFF:        if (!off_q[b]) state_d[b] = PWR_SWITCH_ON;
        PWR_SWITCH_ON:  if (pwr_o.switch_ack_n[b]) state_d[b] = PWR_ON;
        default:        state_d[b] = PWR_ON;
      endcase
      status[b]             = (state_q[b] == PWR_ON);
      pwr_o.clkgate_en_n[b] = (state_q[b] == PWR_ON);
      pwr_o.iso_n[b]        = (state_q[b] == PWR_ON);
      pwr_o.switch_n[b]     = (state_q[b] inside {PWR_ON, PWR_GATE, PWR_SWITCH_ON});
      // retention only counts while the bank is asked off
      pwr_o.retentive_n[b]  = ~(ret_q[b] & off_q[b]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int b = 0; b < NB; b++) begin
        state_q[b] <= PWR_ON;
      end
    end else begin
      for (int b = 0; b < NB; b++) begin
        state_q[b] <= state_d[b];
      end
    end
  end

endmodule

// ==== rtl/gpio_ao.sv ====
// ----------------------------------------
// always-on gpio with edge interrupts
// ----------------------------------------
`timescale 1ns/1ps
`include "mcu_defs_defs.svh"

module gpio_ao (
  input  logic                   clk_i,
  input  logic                   rst_i,
  wb_if.slave                    bus_i,
  input  logic [`MCU_GPIO_W-1:0] gpio_i,
  output logic [`MCU_GPIO_W-1:0] gpio_o,
  output logic [`MCU_GPIO_W-1:0] gpio_oe_o,
  output logic [`MCU_GPIO_W-1:0] intr_o
);
  localparam int GW = `MCU_GPIO_W;
  localparam int DW = `MCU_DATA_W;

  logic [GW-1:0] out_q, oe_q, ie_q, ie_d;
  logic [GW-1:0] sync1_q, sync2_q, prev_q;
  logic [GW-1:0] rise, clr;
  logic [GW-1:0] pend_q, pend_d;
  logic          access;
  logic          wr_en;
  logic          ack_q;
  logic [DW-1:0] rd_mux;
  logic [DW-1:0] rdata_q;

  assign access = bus_i.cyc & bus_i.stb & ~ack_q;
  assign wr_en  = access & bus_i.we;
  assign rise   = sync2_q & ~prev_q;

  // disabling a pin drops its pending bit too
  always_comb begin
    ie_d = ie_q;
    clr  = '0;
    if (wr_en && bus_i.adr.periph.reg_idx == `MCU_GPIO_REG_IE) begin
      ie_d = bus_i.dat_w[GW-1:0];
    end
    if (wr_en && bus_i.adr.periph.reg_idx == `MCU_GPIO_REG_IN) begin
      clr = bus_i.dat_w[GW-1:0];
    end
    pend_d = ((pend_q & ~clr) | rise) & ie_d;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_q   <= '0;
      oe_q    <= '0;
      ie_q    <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
      pend_q  <= '0;
      ack_q   <= 1'b0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      ie_q    <= ie_d;
      pend_q  <= pend_d;
      ack_q   <= access;
      if (wr_en) begin
        case (bus_i.adr.periph.reg_idx)
          `MCU_GPIO_REG_OUT: out_q <= bus_i.dat_w[GW-1:0];
          `MCU_GPIO_REG_OE:  oe_q <= bus_i.dat_w[GW-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rd_mux = '0;
    case (bus_i.adr.periph.reg_idx)
      `MCU_GPIO_REG_OUT: rd_mux[GW-1:0] = out_q;
      `MCU_GPIO_REG_OE:  rd_mux[GW-1:0] = oe_q;
      `MCU_GPIO_REG_IN:  rd_mux[GW-1:0] = sync2_q;
      default:           rd_mux[GW-1:0] = ie_q;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= rd_mux;
    end
  end

  assign bus_i.ack   = ack_q;
  assign bus_i.dat_r = rdata_q;
  assign gpio_o      = out_q;
  assign gpio_oe_o   = oe_q;
  assign intr_o      = pend_q;

  a_intr_enabled: assert property (@(posedge clk_i) disable iff (rst_i)
    (intr_o & ~ie_q) == '0);

endmodule

// ==== rtl/mini_mcu.sv ====
// ----------------------------------------
// mini mcu top level
// ----------------------------------------
`timescale 1ns/1ps
`include "mcu_defs_defs.svh"

module mini_mcu (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [`MCU_ADDR_W-1:0] wb_adr_i,
  input  logic [`MCU_DATA_W-1:0] wb_dat_i,
  output logic [`MCU_DATA_W-1:0] wb_dat_o,
  output logic                   wb_ack_o,
  input  logic [`MCU_GPIO_W-1:0] gpio_i,
  output logic [`MCU_GPIO_W-1:0] gpio_o,
  output logic [`MCU_GPIO_W-1:0] gpio_oe_o,
  output logic [`MCU_GPIO_W-1:0] gpio_intr_o
);
  wb_if  mem_bus ();
  wb_if  pm_bus ();
  wb_if  gpio_bus ();
  pwr_if bank_pwr ();

  system_bus system_bus_i (
    .clk_i,
    .rst_i,
    .wb_cyc_i,
    .wb_stb_i,
    .wb_we_i,
    .wb_adr_i,
    .wb_dat_i,
    .wb_dat_o,
    .wb_ack_o,
    .mem_o (mem_bus),
    .pm_o  (pm_bus),
    .gpio_o(gpio_bus)
  );

  memory_subsystem memory_subsystem_i (
    .clk_i,
    .rst_i,
    .bus_i(mem_bus),
    .pwr_i(bank_pwr)
  );

  // bank power control
  power_manager power_manager_i (
    .clk_i,
    .rst_i,
    .bus_i(pm_bus),
    .pwr_o(bank_pwr)
  );

  gpio_ao gpio_ao_i (
    .clk_i,
    .rst_i,
    .bus_i (gpio_bus),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .intr_o(gpio_intr_o)
  );

endmodule

// ==== bench/tb_mini_mcu.sv ====
// ----------------------------------------
// testbench for the mini mcu with clock,
// reset, stimulus table, bus and compare tasks
// ----------------------------------------
`timescale 1ns/1ps
`include "mcu_defs_defs.svh"

module tb_mini_mcu import mcu_pkg::*; ();
  localparam int DW          = `MCU_DATA_W;
  localparam int AW          = `MCU_ADDR_W;
  localparam int GW          = `MCU_GPIO_W;
  localparam int NB          = `MCU_NUM_BANKS;
  localparam int ACK_LAT     = 2;
  localparam int BUS_LIMIT   = 20;
  localparam int POLL_LIMIT  = 40;
  localparam int INTR_LIMIT  = 20;
  localparam int PIN_SETTLE  = 4;

  typedef enum int {
    OP_WRITE,
    OP_READ,
    OP_POLL,
    OP_SET_PIN,
    OP_CHK_OUT,
    OP_CHK_OE,
    OP_CHK_INTR,
    OP_WAIT_INTR
  } op_e;

  logic          clk_i;
  logic          rst_i;
  logic          wb_cyc_i;
  logic          wb_stb_i;
  logic          wb_we_i;
  logic [AW-1:0] wb_adr_i;
  logic [DW-1:0] wb_dat_i;
  logic [DW-1:0] wb_dat_o;
  logic          wb_ack_o;
  logic [GW-1:0] gpio_i;
  logic [GW-1:0] gpio_o;
  logic [GW-1:0] gpio_oe_o;
  logic [GW-1:0] gpio_intr_o;

  // stimulus table with one entry per index
  string         t_name[$];
  op_e           t_op[$];
  logic [AW-1:0] t_addr[$];
  logic [DW-1:0] t_wdata[$];
  logic [DW-1:0] t_exp[$];
  logic [DW-1:0] t_mask[$];

  logic [DW-1:0] pat [NB][2];
  integer        seed;
  int            value_errs;
  int            timeout_errs;

  mini_mcu mini_mcu_inst (
    .clk_i,
    .rst_i,
    .wb_cyc_i,
    .wb_stb_i,
    .wb_we_i,
    .wb_adr_i,
    .wb_dat_i,
    .wb_dat_o,
    .wb_ack_o,
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .gpio_intr_o
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // bank in bits 9:8, word in bits 7:2
  function automatic logic [AW-1:0] ram_addr(input int bank, input int word);
    return AW'((bank << 8) | (word << 2));
  endfunction

  // region bit set, block in bits 5:4, register in bits 3:2
  function automatic logic [AW-1:0] periph_addr(input int blk, input int idx);
    return AW'(16'h8000 | (blk << 4) | (idx << 2));
  endfunction

  function automatic int word_of(input int bank, input int k);
    return (k == 0) ? bank * 13 + 3 : 60 - bank * 5;
  endfunction

  task automatic check_word(input string name, input logic [DW-1:0] exp,
                            input logic [DW-1:0] act);
    if (act !== exp) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_gpio(input string name, input logic [GW-1:0] exp,
                            input logic [GW-1:0] act);
    if (act !== exp) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("FAIL %s latency expected %0d actual %0d", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic add_entry(input string name, input op_e op, input logic [AW-1:0] addr,
                           input logic [DW-1:0] wdata, input logic [DW-1:0] exp,
                           input logic [DW-1:0] mask);
    t_name.push_back(name);
    t_op.push_back(op);
    t_addr.push_back(addr);
    t_wdata.push_back(wdata);
    t_exp.push_back(exp);
    t_mask.push_back(mask);
  endtask

  // starts on a falling edge and ends on one after an idle cycle
  task automatic bus_transfer(input string name, input logic we, input logic [AW-1:0] adr,
                              input logic [DW-1:0] wdat, output logic [DW-1:0] rdat);
    int lat;
    bit got;
    lat      = 0;
    got      = 1'b0;
    rdat     = '0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdat;
    while (!got && lat < BUS_LIMIT) begin
      @(negedge clk_i);
      lat++;
      if (wb_ack_o) begin
        got  = 1'b1;
        rdat = wb_dat_o;
      end
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    if (!got) begin
      $display("timeout: no bus acknowledge for %s", name);
      timeout_errs++;
    end else begin
      check_latency(name, ACK_LAT, lat);
    end
    @(negedge clk_i);
  endtask

  task automatic build_table();
    for (int b = 0; b < NB; b++) begin
      for (int k = 0; k < 2; k++) begin
        pat[b][k] = $random(seed);
        add_entry($sformatf("ram_wr_b%0d_w%0d", b, word_of(b, k)), OP_WRITE,
                  ram_addr(b, word_of(b, k)), pat[b][k], '0, '0);
      end
    end
    for (int b = 0; b < NB; b++) begin
      for (int k = 0; k < 2; k++) begin
        add_entry($sformatf("ram_rd_b%0d_w%0d", b, word_of(b, k)), OP_READ,
                  ram_addr(b, word_of(b, k)), '0, pat[b][k], '0);
      end
    end
    // unmapped blocks answer with zero
    add_entry("unmapped_rd_blk2", OP_READ, periph_addr(2, 0), '0, '0, '0);
    add_entry("unmapped_wr_blk3", OP_WRITE, periph_addr(3, 1), 32'h1234_5678, '0, '0);
    add_entry("unmapped_rd_blk3", OP_READ, periph_addr(3, 1), '0, '0, '0);

    // bank 1 off and back without retention
    add_entry("pm_status_reset", OP_READ, periph_addr(BLK_PM, `MCU_PM_REG_STATUS),
              '0, 32'hf, '0);
    add_entry("pm_off_b1", OP_WRITE, periph_addr(BLK_PM, `MCU_PM_REG_OFF), 32'h2, '0, '0);
    add_entry("pm_poll_b1_off", OP_POLL, periph_addr(BLK_PM, `MCU_PM_REG_STATUS),
              '0, 32'h0, 32'h2);
    add_entry("ram_rd_b1_off", OP_READ, ram_addr(1, word_of(1, 0)), '0, '0, '0);
    add_entry("ram_wr_b1_gated", OP_WRITE, ram_addr(1, 20), 32'hdead_beef, '0, '0);
    add_entry("ram_rd_b0_kept", OP_READ, ram_addr(0, word_of(0, 0)), '0, pat[0][0], '0);
    add_entry("pm_on_b1", OP_WRITE, periph_addr(BLK_PM, `MCU_PM_REG_OFF), 32'h0, '0, '0);
    add_entry("pm_poll_b1_on", OP_POLL, periph_addr(BLK_PM, `MCU_PM_REG_STATUS),
              '0, 32'h2, 32'h2);
    add_entry("ram_rd_b1_lost0", OP_READ, ram_addr(1, word_of(1, 0)), '0, '0, '0);
    add_entry("ram_rd_b1_lost1", OP_READ, ram_addr(1, word_of(1, 1)), '0, '0, '0);
    add_entry("ram_rd_b1_w20", OP_READ, ram_addr(1, 20), '0, '0, '0);

    // bank 2 with retention
    add_entry("pm_ret_b2", OP_WRITE, periph_addr(BLK_PM, `MCU_PM_REG_RET), 32'h4, '0, '0);
    add_entry("pm_off_b2", OP_WRITE, periph_addr(BLK_PM, `MCU_PM_REG_OFF), 32'h4, '0, '0);
    add_entry("pm_poll_b2_off", OP_POLL, periph_addr(BLK_PM, `MCU_PM_REG_STATUS),
              '0, 32'h0, 32'h4);
    add_entry("ram_rd_b2_off", OP_READ, ram_addr(2, word_of(2, 0)), '0, '0, '0);
    add_entry("pm_on_b2", OP_WRITE, periph_addr(BLK_PM, `MCU_PM_REG_OFF), 32'h0, '0, '0);
    add_entry("pm_poll_b2_on", OP_POLL, periph_addr(BLK_PM, `MCU_PM_REG_STATUS),
              '0, 32'h4, 32'h4);
    for (int k = 0; k < 2; k++) begin
      add_entry($sformatf("ram_rd_b2_ret%0d", k), OP_READ, ram_addr(2, word_of(2, k)),
                '0, pat[2][k], '0);
    end
    // banks that stayed powered
    for (int k = 0; k < 2; k++) begin
      add_entry($sformatf("ram_rd_b0_end%0d", k), OP_READ, ram_addr(0, word_of(0, k)),
                '0, pat[0][k], '0);
      add_entry($sformatf("ram_rd_b3_end%0d", k), OP_READ, ram_addr(3, word_of(3, k)),
                '0, pat[3][k], '0);
    end
    add_entry("pm_status_end", OP_READ, periph_addr(BLK_PM, `MCU_PM_REG_STATUS),
              '0, 32'hf, '0);

    // gpio outputs and input path
    add_entry("gpio_wr_out", OP_WRITE, periph_addr(BLK_GPIO, `MCU_GPIO_REG_OUT),
              32'ha5, '0, '0);
    add_entry("gpio_wr_oe", OP_WRITE, periph_addr(BLK_GPIO, `MCU_GPIO_REG_OE),
              32'h3c, '0, '0);
    add_entry("gpio_pin_out", OP_CHK_OUT, '0, '0, 32'ha5, '0);
    add_entry("gpio_pin_oe", OP_CHK_OE, '0, '0, 32'h3c, '0);
    add_entry("gpio_rd_out", OP_READ, periph_addr(BLK_GPIO, `MCU_GPIO_REG_OUT),
              '0, 32'ha5, '0);
    add_entry("gpio_pins_81", OP_SET_PIN, '0, 32'h81, '0, '0);
    add_entry("gpio_rd_in_81", OP_READ, periph_addr(BLK_GPIO, `MCU_GPIO_REG_IN),
              '0, 32'h81, '0);
    add_entry("gpio_intr_none", OP_CHK_INTR, '0, '0, 32'h0, '0);

    // interrupts on pin 3 only
    add_entry("gpio_wr_ie", OP_WRITE, periph_addr(BLK_GPIO, `MCU_GPIO_REG_IE),
              32'h08, '0, '0);
    add_entry("gpio_pins_89", OP_SET_PIN, '0, 32'h89, '0, '0);
    add_entry("gpio_wait_intr3", OP_WAIT_INTR, '0, '0, 32'h08, 32'h08);
    add_entry("gpio_intr3", OP_CHK_INTR, '0, '0, 32'h08, '0);
    add_entry("gpio_pins_8b", OP_SET_PIN, '0, 32'h8b, '0, '0);
    add_entry("gpio_intr1_masked", OP_CHK_INTR, '0, '0, 32'h08, '0);
    add_entry("gpio_clr_intr3", OP_WRITE, periph_addr(BLK_GPIO, `MCU_GPIO_REG_IN),
              32'h08, '0, '0);
    add_entry("gpio_intr_cleared", OP_CHK_INTR, '0, '0, 32'h0, '0);
    add_entry("gpio_rd_in_8b", OP_READ, periph_addr(BLK_GPIO, `MCU_GPIO_REG_IN),
              '0, 32'h8b, '0);
  endtask

  task automatic run_entry(input int i);
    logic [DW-1:0] rdat;
    int            n;
    bit            hit;
    hit = 1'b0;
    n   = 0;
    case (t_op[i])
      OP_WRITE: bus_transfer(t_name[i], 1'b1, t_addr[i], t_wdata[i], rdat);
      OP_READ: begin
        bus_transfer(t_name[i], 1'b0, t_addr[i], '0, rdat);
        check_word(t_name[i], t_exp[i], rdat);
      end
      OP_POLL: begin
        while (!hit && n < POLL_LIMIT) begin
          bus_transfer(t_name[i], 1'b0, t_addr[i], '0, rdat);
          hit = ((rdat & t_mask[i]) == t_exp[i]);
          n++;
        end
        if (!hit) begin
          $display("timeout: status poll %s never reached the expected value", t_name[i]);
          timeout_errs++;
        end
      end
      OP_SET_PIN: begin
        gpio_i = t_wdata[i][GW-1:0];
        // two synchronizer flops plus edge detect
        repeat (PIN_SETTLE) @(negedge clk_i);
      end
      OP_CHK_OUT:  check_gpio(t_name[i], t_exp[i][GW-1:0], gpio_o);
      OP_CHK_OE:   check_gpio(t_name[i], t_exp[i][GW-1:0], gpio_oe_o);
      OP_CHK_INTR: check_gpio(t_name[i], t_exp[i][GW-1:0], gpio_intr_o);
      OP_WAIT_INTR: begin
        while (!hit && n < INTR_LIMIT) begin
          hit = ((gpio_intr_o & t_mask[i][GW-1:0]) == t_exp[i][GW-1:0]);
          if (!hit) begin
            @(negedge clk_i);
          end
          n++;
        end
        if (!hit) begin
          $display("timeout: interrupt for %s never arrived", t_name[i]);
          timeout_errs++;
        end
      end
      default: ;
    endcase
  endtask

  initial begin
    rst_i        = 1'b1;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    wb_we_i      = 1'b0;
    wb_adr_i     = '0;
    wb_dat_i     = '0;
    gpio_i       = '0;
    seed         = 52027;
    value_errs   = 0;
    timeout_errs = 0;
    build_table();

    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    if (wb_ack_o !== 1'b0) begin
      $display("bus acknowledge is not low after reset");
      value_errs++;
    end
    check_gpio("reset_oe", '0, gpio_oe_o);
    check_gpio("reset_intr", '0, gpio_intr_o);

    for (int i = 0; i < t_name.size(); i++) begin
      run_entry(i);
    end

    $display("errors: %0d value mismatches, %0d timeouts", value_errs, timeout_errs);
    if (value_errs + timeout_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+include
rtl/mcu_pkg.sv
rtl/mcu_if.sv
rtl/system_bus.sv
rtl/memory_subsystem.sv
rtl/power_manager.sv
rtl/gpio_ao.sv
rtl/mini_mcu.sv
bench/tb_mini_mcu.sv
